// File: Bender.yml
package:
  name: lsu

sources:
  - hdl/lsu_pkg.sv
  - hdl/lsu_align.sv
  - hdl/lsu_bus_fsm.sv
  - hdl/clint_timer.sv
  - hdl/lsu_extract.sv
  - hdl/lsu_top.sv
  - target: simulation
    files:
      - verification/lsu_chk.sv
      - verification/lsu_tb.sv

// File: hdl/clint_timer.sv
`timescale 1ns/100ps
`default_nettype none

module clint_timer import lsu_pkg::*; (
    input  wire   clk,
    input  wire   reset,
    input  wire   tim_valid,
    input  wire   tim_addr_hi,
    output data_t tim_rdata,
    output logic  tim_rvalid
);

    mtime_t mtime;

    // free running, one tick per clock
    always_ff @(posedge clk) begin
        if (reset) begin
            mtime      <= '0;
            tim_rvalid <= 1'b0;
        end else begin
            mtime      <= mtime + 64'd1;
            tim_rvalid <= tim_valid;
        end
    end

    // word select by address bit 2
    always_ff @(posedge clk) begin
        if (tim_valid) begin
            tim_rdata <= tim_addr_hi ? mtime[63:32] : mtime[31:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/lsu_align.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_align import lsu_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  lsu_req_t   req,
    input  wire        req_valid,
    output logic       req_ready,
    output logic       start,
    output lsu_stage_t stage,
    input  wire        idle
);

    lsu_req_t req_q;
    logic     busy;
    logic     pend;
    data_t    wdata_al;
    strb_t    strb_al;
    axsize_t  axsize_al;

    // ready again in the cycle the response goes out
    assign req_ready = !busy || idle;

    // store data moves to its byte lane
    assign wdata_al = req_q.wdata << {req_q.addr[1:0], 3'b000};

    always_comb begin
        unique case (req_q.size)
            SIZE_NONE: begin
                strb_al   = '0;
                axsize_al = 3'd0;
            end
            SIZE_BYTE: begin
                strb_al   = strb_t'(4'b0001) << req_q.addr[1:0];
                axsize_al = 3'd0;
            end
            SIZE_HALF: begin
                strb_al   = req_q.addr[1] ? 4'b1100 : 4'b0011;
                axsize_al = 3'd1;
            end
            SIZE_WORD: begin
                strb_al   = 4'b1111;
                axsize_al = 3'd2;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            pend  <= 1'b0;
            start <= 1'b0;
        end else begin
            pend  <= req_valid && req_ready;
            start <= pend;
            if (req_valid && req_ready) begin
                busy <= 1'b1;
            end else if (idle) begin
                busy <= 1'b0;
            end
        end
    end

    // capture, then register the aligned form a cycle later
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (pend) begin
            stage <= '{req: req_q, wdata: wdata_al, strb: strb_al, axsize: axsize_al};
        end
    end

endmodule

`default_nettype wire

// File: hdl/lsu_bus_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_bus_fsm import lsu_pkg::*; #(
    parameter addr_t       CLINT_BASE = 32'ha000_0048,
    parameter int unsigned CLINT_SIZE = 8
) (
    input  wire        clk,
    input  wire        reset,
    input  wire        start,
    input  lsu_stage_t stage,
    output axi_ax_t    aw,
    output logic       awvalid,
    input  wire        awready,
    output axi_w_t     w,
    output logic       wvalid,
    input  wire        wready,
    input  resp_t      bresp,
    input  wire        bvalid,
    output logic       bready,
    output axi_ax_t    ar,
    output logic       arvalid,
    input  wire        arready,
    input  axi_r_t     r,
    input  wire        rvalid,
    output logic       rready,
    output logic       tim_valid,
    output logic       tim_addr_hi,
    input  data_t      tim_rdata,
    input  wire        tim_rvalid,
    output logic       done,
    output data_t      raw,
    output logic       err,
    output lsu_meta_t  meta
);

    bus_state_e state;
    logic       is_tim;
    axi_ax_t    ax_q;
    axi_w_t     w_q;
    addr_t      win_off;
    logic       in_window;

    // unsigned offset check covers both window bounds
    assign win_off   = stage.req.addr - CLINT_BASE;
    assign in_window = win_off < addr_t'(CLINT_SIZE);

    assign aw          = ax_q;
    assign ar          = ax_q;
    assign w           = w_q;
    assign awvalid     = (state == AW);
    assign wvalid      = (state == W);
    assign bready      = (state == B);
    assign arvalid     = (state == AR);
    assign rready      = (state == R) && !is_tim;
    assign tim_addr_hi = meta.addr[2];
    assign done        = (state == DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            is_tim    <= 1'b0;
            tim_valid <= 1'b0;
        end else begin
            tim_valid <= 1'b0;
            unique case (state)
                IDLE: begin
                    if (start) begin
                        is_tim <= in_window;
                        if (in_window) begin
                            // timer writes are dropped
                            if (stage.req.write) begin
                                state <= DONE;
                            end else begin
                                state     <= R;
                                tim_valid <= 1'b1;
                            end
                        end else if (stage.req.write) begin
                            state <= AW;
                        end else begin
                            state <= AR;
                        end
                    end
                end
                AW:   if (awready) state <= W;
                W:    if (wready) state <= B;
                B:    if (bvalid) state <= DONE;
                AR:   if (arready) state <= R;
                R:    if (is_tim ? tim_rvalid : rvalid) state <= DONE;
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            ax_q <= '{addr: stage.req.addr, size: stage.axsize};
            w_q  <= '{data: stage.wdata, strb: stage.strb};
            meta <= '{addr: stage.req.addr, size: stage.req.size, sign: stage.req.sign};
            raw  <= '0;
            err  <= 1'b0;
        end
        if (state == B && bvalid) begin
            err <= (bresp != RESP_OKAY);
        end
        if (state == R && !is_tim && rvalid) begin
            raw <= r.data;
            err <= (r.resp != RESP_OKAY);
        end
        if (state == R && is_tim && tim_rvalid) begin
            raw <= tim_rdata;
        end
    end

endmodule

`default_nettype wire

// File: hdl/lsu_extract.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_extract import lsu_pkg::*; (
    input  wire       clk,
    input  wire       reset,
    input  wire       done,
    input  data_t     raw,
    input  wire       err,
    input  lsu_meta_t meta,
    output lsu_resp_t resp,
    output logic      resp_valid
);

    data_t shifted;
    data_t ext;

    // bring the addressed lane down to bit 0
    assign shifted = raw >> {meta.addr[1:0], 3'b000};

    always_comb begin
        unique case (meta.size)
            SIZE_NONE: ext = '0;
            SIZE_BYTE: ext = {{24{shifted[7] & meta.sign}}, shifted[7:0]};
            SIZE_HALF: ext = {{16{shifted[15] & meta.sign}}, shifted[15:0]};
            SIZE_WORD: ext = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            resp <= '{rdata: ext, err: err};
        end
    end

endmodule

`default_nettype wire

// File: hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [63:0]       mtime_t;
    typedef logic [1:0]        size_t;
    typedef logic [2:0]        axsize_t;
    typedef logic [1:0]        resp_t;

    // access size codes, 0 means no access
    localparam size_t SIZE_NONE = 2'd0;
    localparam size_t SIZE_BYTE = 2'd1;
    localparam size_t SIZE_HALF = 2'd2;
    localparam size_t SIZE_WORD = 2'd3;

    localparam resp_t RESP_OKAY = 2'b00;

    // core request, one at a time
    typedef struct packed {
        logic  write;
        size_t size;
        logic  sign;
        addr_t addr;
        data_t wdata;
    } lsu_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } lsu_resp_t;

    // shared by aw and ar
    typedef struct packed {
        addr_t   addr;
        axsize_t size;
    } axi_ax_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } axi_w_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } axi_r_t;

    // request stage to bus stage
    typedef struct packed {
        lsu_req_t req;
        data_t    wdata;
        strb_t    strb;
        axsize_t  axsize;
    } lsu_stage_t;

    // what the response stage needs to extract load data
    typedef struct packed {
        addr_t addr;
        size_t size;
        logic  sign;
    } lsu_meta_t;

    typedef enum logic [2:0] {
        IDLE,
        AW,
        W,
        B,
        AR,
        R,
        DONE
    } bus_state_e;

endpackage

`default_nettype wire

// File: hdl/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter addr_t       CLINT_BASE = 32'ha000_0048,
    parameter int unsigned CLINT_SIZE = 8
) (
    input  wire       clk,
    input  wire       reset,
    input  lsu_req_t  req,
    input  wire       req_valid,
    output logic      req_ready,
    output lsu_resp_t resp,
    output logic      resp_valid,
    output axi_ax_t   aw,
    output logic      awvalid,
    input  wire       awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  wire       wready,
    input  resp_t     bresp,
    input  wire       bvalid,
    output logic      bready,
    output axi_ax_t   ar,
    output logic      arvalid,
    input  wire       arready,
    input  axi_r_t    r,
    input  wire       rvalid,
    output logic      rready
);

    logic       start;
    lsu_stage_t stage;
    logic       tim_valid;
    logic       tim_addr_hi;
    data_t      tim_rdata;
    logic       tim_rvalid;
    logic       done;
    data_t      raw;
    logic       err;
    lsu_meta_t  meta;

    lsu_align i_align (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .start     (start),
        .stage     (stage),
        .idle      (resp_valid)
    );

    lsu_bus_fsm #(
        .CLINT_BASE (CLINT_BASE),
        .CLINT_SIZE (CLINT_SIZE)
    ) i_bus_fsm (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .stage       (stage),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .w           (w),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready),
        .tim_valid   (tim_valid),
        .tim_addr_hi (tim_addr_hi),
        .tim_rdata   (tim_rdata),
        .tim_rvalid  (tim_rvalid),
        .done        (done),
        .raw         (raw),
        .err         (err),
        .meta        (meta)
    );

    clint_timer i_timer (
        .clk         (clk),
        .reset       (reset),
        .tim_valid   (tim_valid),
        .tim_addr_hi (tim_addr_hi),
        .tim_rdata   (tim_rdata),
        .tim_rvalid  (tim_rvalid)
    );

    lsu_extract i_extract (
        .clk        (clk),
        .reset      (reset),
        .done       (done),
        .raw        (raw),
        .err        (err),
        .meta       (meta),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

endmodule

`default_nettype wire

// File: lsu.f
hdl/lsu_pkg.sv
hdl/lsu_align.sv
hdl/lsu_bus_fsm.sv
hdl/clint_timer.sv
hdl/lsu_extract.sv
hdl/lsu_top.sv
verification/lsu_chk.sv
verification/lsu_tb.sv

// File: verification/lsu_chk.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_chk import lsu_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire        start,
    input  bus_state_e state,
    input  axi_ax_t    aw,
    input  wire        awvalid,
    input  wire        awready,
    input  axi_w_t     w,
    input  wire        wvalid,
    input  wire        wready,
    input  axi_ax_t    ar,
    input  wire        arvalid,
    input  wire        arready
);

    // a stalled channel keeps valid and payload
    assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("aw valid dropped or payload changed while stalled");

    assert property (@(posedge clk) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("w valid dropped or payload changed while stalled");

    assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("ar valid dropped or payload changed while stalled");

    // one request at a time, so start only ever finds the bus stage idle
    assert property (@(posedge clk) disable iff (reset) start |-> state == IDLE)
        else $error("start arrived while the bus stage was busy");

endmodule

bind lsu_bus_fsm lsu_chk i_chk (.*);

`default_nettype wire

// File: verification/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam addr_t CLINT_BASE  = 32'ha000_0048;
    localparam int    TIMEOUT_CYC = 200;
    localparam int    ERR_IDX     = 240;
    localparam int    K_FULL      = 0;
    localparam int    K_ERR_ONLY  = 1;
    localparam int    K_TIMER     = 2;

    logic      clk;
    logic      reset;
    lsu_req_t  req;
    logic      req_valid;
    logic      req_ready;
    lsu_resp_t resp;
    logic      resp_valid;
    axi_ax_t   aw;
    logic      awvalid;
    logic      awready;
    axi_w_t    w;
    logic      wvalid;
    logic      wready;
    resp_t     bresp;
    logic      bvalid;
    logic      bready;
    axi_ax_t   ar;
    logic      arvalid;
    logic      arready;
    axi_r_t    r;
    logic      rvalid;
    logic      rready;

    // slave memory and the testbench's own view of it
    data_t       mem [256];
    data_t       shadow [256];
    logic [31:0] lfsr;
    lsu_resp_t   exp_q [$];
    int          kind_q [$];
    string       name_q [$];
    axi_ax_t     exp_ax_q [$];
    data_t       tim_q [$];
    int          n_err = 0;
    int          n_timeout = 0;
    int          n_req = 0;
    int          n_resp = 0;
    int          n_aw = 0;
    int          n_w = 0;
    int          n_ar = 0;

    lsu_top #(
        .CLINT_BASE (CLINT_BASE),
        .CLINT_SIZE (8)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .aw         (aw),
        .awvalid    (awvalid),
        .awready    (awready),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .ar         (ar),
        .arvalid    (arvalid),
        .arready    (arready),
        .r          (r),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    // expected load value from the extraction rule
    function automatic data_t ref_load(input data_t word, input addr_t a, input size_t sz,
                                       input logic sg);
        logic [63:0]        wide;
        logic signed [7:0]  b;
        logic signed [15:0] h;
        wide = {32'h0, word};
        b = wide[8*a[1:0] +: 8];
        h = wide[8*a[1:0] +: 16];
        case (sz)
            SIZE_BYTE: return sg ? data_t'(int'(b)) : {24'h0, b};
            SIZE_HALF: return sg ? data_t'(int'(h)) : {16'h0, h};
            SIZE_WORD: return word;
            default:   return '0;
        endcase
    endfunction

    task automatic finish_run();
        $display("errors: %0d check, %0d timeout; %0d requests, %0d responses",
                 n_err, n_timeout, n_req, n_resp);
        if (n_err == 0 && n_timeout == 0 && n_req == n_resp) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic tick_or_timeout(inout int cnt, input string what);
        @(negedge clk);
        cnt++;
        if (cnt > TIMEOUT_CYC) begin
            $display("timeout: no %s within %0d cycles", what, TIMEOUT_CYC);
            n_timeout++;
            finish_run();
        end
    endtask

    task automatic check_resp(input string name, input lsu_resp_t exp, input lsu_resp_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
            n_err++;
        end
    endtask

    task automatic check_word(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
            n_err++;
        end
    endtask

    task automatic check_mtime(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
            n_err++;
        end
    endtask

    task automatic check_ax(input string name, input axi_ax_t exp, input axi_ax_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
            n_err++;
        end
    endtask

    // each address phase belongs to the oldest memory request not yet seen on the bus
    task automatic expect_addr_phase(input string chan, input axi_ax_t act);
        axi_ax_t exp;
        if (exp_ax_q.size() == 0) begin
            $display("%s address phase with no memory request outstanding", chan);
            n_err++;
        end else begin
            exp = exp_ax_q.pop_front();
            check_ax(chan, exp, act);
        end
    endtask

    // queues the expected response, then drives the request
    task automatic do_req(input string name, input logic wr, input size_t sz, input logic sg,
                          input addr_t a, input data_t wd);
        lsu_resp_t exp;
        axi_ax_t   ax;
        logic      tim;
        logic      bad;
        int        idx;
        int        off;
        int        nb;
        int        cnt;
        tim = (a >= CLINT_BASE) && (a < CLINT_BASE + 8);
        bad = !tim && (a[9:2] == ERR_IDX);
        idx = a[9:2];
        off = a[1:0];
        nb = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
        // axi size is log2 of the bytes in the beat
        ax.addr = a;
        ax.size = axsize_t'($clog2(nb));
        exp.err = bad;
        exp.rdata = '0;
        if (!tim && !wr) begin
            exp.rdata = ref_load(shadow[idx], a, sz, sg);
        end
        if (!tim && wr && !bad) begin
            for (int k = 0; k < 4; k++) begin
                if (k >= off && k < off + nb) begin
                    shadow[idx][8*k +: 8] = wd[8*(k-off) +: 8];
                end
            end
        end
        if (!tim) begin
            exp_ax_q.push_back(ax);
        end
        exp_q.push_back(exp);
        kind_q.push_back((tim && !wr) ? K_TIMER : ((wr || bad) ? K_ERR_ONLY : K_FULL));
        name_q.push_back(name);
        req = '{write: wr, size: sz, sign: sg, addr: a, wdata: wd};
        req_valid = 1'b1;
        cnt = 0;
        while (!req_ready) begin
            tick_or_timeout(cnt, "req_ready");
        end
        @(negedge clk);
        req_valid = 1'b0;
        n_req++;
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            tick_or_timeout(cnt, "response");
        end
    endtask

    task automatic serve_write();
        axi_ax_t a;
        axi_w_t  wd;
        int      cnt;
        n_aw++;
        repeat (rand_bits(2)) @(negedge clk);
        awready = 1'b1;
        a = aw;
        expect_addr_phase("aw", a);
        @(negedge clk);
        awready = 1'b0;
        cnt = 0;
        while (!wvalid) begin
            tick_or_timeout(cnt, "wvalid");
        end
        n_w++;
        repeat (rand_bits(2)) @(negedge clk);
        wready = 1'b1;
        wd = w;
        @(negedge clk);
        wready = 1'b0;
        // erroring address keeps its old contents
        if (a.addr[9:2] != ERR_IDX) begin
            for (int k = 0; k < 4; k++) begin
                if (wd.strb[k]) begin
                    mem[a.addr[9:2]][8*k +: 8] = wd.data[8*k +: 8];
                end
            end
        end
        repeat (rand_bits(2)) @(negedge clk);
        bresp = (a.addr[9:2] == ERR_IDX) ? 2'b10 : RESP_OKAY;
        bvalid = 1'b1;
        cnt = 0;
        while (!bready) begin
            tick_or_timeout(cnt, "bready");
        end
        @(negedge clk);
        bvalid = 1'b0;
    endtask

    task automatic serve_read();
        axi_ax_t a;
        int      cnt;
        n_ar++;
        repeat (rand_bits(2)) @(negedge clk);
        arready = 1'b1;
        a = ar;
        expect_addr_phase("ar", a);
        @(negedge clk);
        arready = 1'b0;
        repeat (rand_bits(2)) @(negedge clk);
        r = '{data: mem[a.addr[9:2]], resp: (a.addr[9:2] == ERR_IDX) ? 2'b10 : RESP_OKAY};
        rvalid = 1'b1;
        cnt = 0;
        while (!rready) begin
            tick_or_timeout(cnt, "rready");
        end
        @(negedge clk);
        rvalid = 1'b0;
    endtask

    // axi slave model
    initial begin
        forever begin
            @(negedge clk);
            if (!reset && awvalid) begin
                serve_write();
            end else if (!reset && arvalid) begin
                serve_read();
            end
        end
    end

    always @(negedge clk) begin : compare_resp
        lsu_resp_t act;
        lsu_resp_t exp;
        int        kind;
        string     name;
        if (!reset && resp_valid) begin
            act = resp;
            if (exp_q.size() == 0) begin
                $display("response arrived with no request outstanding");
                n_err++;
            end else begin
                exp = exp_q.pop_front();
                kind = kind_q.pop_front();
                name = name_q.pop_front();
                // timer values are checked by the timer test itself
                if (kind == K_TIMER) begin
                    tim_q.push_back(act.rdata);
                end
                if (kind != K_FULL) begin
                    act.rdata = exp.rdata;
                end
                check_resp(name, exp, act);
                n_resp++;
            end
        end
    end

    initial begin : main
        int    idx;
        int    off;
        int    sz;
        int    bus_before;
        data_t wd;

        lfsr = 32'h85ba_9f10;
        reset = 1'b1;
        req = '0;
        req_valid = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bresp = RESP_OKAY;
        bvalid = 1'b0;
        arready = 1'b0;
        r = '0;
        rvalid = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h33};
            shadow[i] = mem[i];
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (!req_ready || resp_valid || awvalid || wvalid || arvalid || bready || rready) begin
            $display("core or bus outputs not idle after reset");
            n_err++;
        end

        // word store, word load
        repeat (8) begin
            idx = rand_bits(7);
            wd = data_t'(rand_bits(32));
            do_req("word_store", 1'b1, SIZE_WORD, 1'b0, addr_t'(idx * 4), wd);
            do_req("word_load", 1'b0, SIZE_WORD, 1'b0, addr_t'(idx * 4), '0);
            wait_drain();
            check_word("word_store_mem", shadow[idx], mem[idx]);
        end

        // one sub-word store per word, rest of the word must survive
        for (off = 0; off < 4; off++) begin
            do_req("byte_store", 1'b1, SIZE_BYTE, 1'b0, addr_t'((16 + off) * 4 + off),
                   data_t'(rand_bits(32)));
        end
        for (off = 0; off < 4; off += 2) begin
            do_req("half_store", 1'b1, SIZE_HALF, 1'b0, addr_t'((20 + off / 2) * 4 + off),
                   data_t'(rand_bits(32)));
        end
        for (idx = 16; idx < 22; idx++) begin
            do_req("merged_load", 1'b0, SIZE_WORD, 1'b0, addr_t'(idx * 4), '0);
        end
        wait_drain();
        for (idx = 16; idx < 22; idx++) begin
            check_word("lane_merge_mem", shadow[idx], mem[idx]);
        end

        // sub-word loads with mixed sign bits per lane
        do_req("sign_word_store", 1'b1, SIZE_WORD, 1'b0, 32'd96, 32'h8f7e_80c1);
        for (int sg = 0; sg < 2; sg++) begin
            for (off = 0; off < 4; off++) begin
                do_req("byte_load", 1'b0, SIZE_BYTE, sg[0], addr_t'(96 + off), '0);
            end
            for (off = 0; off < 3; off++) begin
                do_req("half_load", 1'b0, SIZE_HALF, sg[0], addr_t'(96 + off), '0);
            end
        end
        wait_drain();

        // back to back mixed traffic
        repeat (40) begin
            sz = rand_bits(2);
            if (sz == 0) begin
                sz = SIZE_WORD;
            end
            off = (sz == SIZE_WORD) ? 0 : (sz == SIZE_HALF) ? rand_bits(1) * 2 : rand_bits(2);
            idx = rand_bits(7);
            do_req("mixed", rand_bits(1), size_t'(sz), rand_bits(1), addr_t'(idx * 4 + off),
                   data_t'(rand_bits(32)));
        end
        wait_drain();
        for (int i = 0; i < 256; i++) begin
            check_word("mem_image", shadow[i], mem[i]);
        end

        // slave error on one address
        do_req("err_load", 1'b0, SIZE_WORD, 1'b0, addr_t'(ERR_IDX * 4), '0);
        do_req("err_store", 1'b1, SIZE_WORD, 1'b0, addr_t'(ERR_IDX * 4), 32'h1234_5678);
        do_req("ok_load", 1'b0, SIZE_WORD, 1'b0, 32'd0, '0);
        wait_drain();

        // timer reads
        do_req("timer_lo", 1'b0, SIZE_WORD, 1'b0, CLINT_BASE, '0);
        wait_drain();
        do_req("timer_lo", 1'b0, SIZE_WORD, 1'b0, CLINT_BASE, '0);
        wait_drain();
        do_req("timer_hi", 1'b0, SIZE_WORD, 1'b0, CLINT_BASE + 4, '0);
        wait_drain();
        if (tim_q.size() != 3) begin
            $display("timer reads returned %0d values instead of 3", tim_q.size());
            n_err++;
        end else begin
            if (!(tim_q[1] > tim_q[0])) begin
                $display("CHECK FAILED timer_increase: expected above %h actual %h",
                         tim_q[0], tim_q[1]);
                n_err++;
            end
            check_mtime("timer_hi", '0, tim_q[2]);
        end

        // timer store stays off the bus
        bus_before = n_aw + n_w + n_ar;
        do_req("timer_store", 1'b1, SIZE_WORD, 1'b0, CLINT_BASE, 32'hdead_beef);
        wait_drain();
        if (n_aw + n_w + n_ar != bus_before) begin
            $display("timer store caused traffic on the AXI channels");
            n_err++;
        end

        finish_run();
    end

endmodule

`default_nettype wire
